// ==== fdiv_macros.svh ====
/*
 * widths, exponent bias, quotient bit count and latency
 * shared by the single precision divide pipe
 */

`ifndef FDIV_MACROS_SVH
`define FDIV_MACROS_SVH

// significand with hidden bit
`define FDIV_FRAC_W 24

`define FDIV_EXP_BIAS 127          // single precision bias

// one quotient bit per iteration cycle
`define FDIV_QBITS 26

`define FDIV_LATENCY 30            // start strobe to done strobe

`endif

// ==== fdiv_pkg.sv ====
/*
 * divide pipe types
 * ieee word, significand, exponent, shift count, quotient, iteration fsm
 */

`include "fdiv_macros.svh"

package fdiv_pkg;

	// raw single precision word
	typedef logic [31:0] word_t;

	// significand with hidden bit at the top
	typedef logic [`FDIV_FRAC_W-1:0] frac_t;

	// signed so the difference can go below zero or past 254
	typedef logic signed [9:0] exp_t;

	typedef logic [4:0] shl_cnt_t;               // lead zero count of a significand

	// integer bit at the top, then fraction bits
	typedef logic [`FDIV_QBITS-1:0] quot_t;

	typedef enum logic [1:0] {
		IDLE,                                // waiting for normalized operands
		ITER,                                // one quotient bit per cycle
		DONE                                 // quotient handed to pack stage
	} iter_state_t;

endpackage

// ==== fdiv_stage_if.sv ====
/*
 * one divide operation passed between two pipe stages
 */

`timescale 1ns/100ps

interface fdiv_stage_if;

	logic            valid;              // one cycle strobe
	logic            sign;               // quotient sign
	fdiv_pkg::exp_t  exp_a;              // dividend exp, later quotient exp
	fdiv_pkg::exp_t  exp_b;              // divisor exp, zero after norm
	fdiv_pkg::frac_t frac_a;             // dividend significand or quotient msbs
	fdiv_pkg::frac_t frac_b;             // divisor significand or quotient lsbs
	logic            special;            // result is a fixed word
	fdiv_pkg::word_t special_word;       // fixed result

	// upstream stage
	modport src (
		output valid, sign, exp_a, exp_b, frac_a, frac_b,
		output special, special_word
	);

	// downstream stage, payload taken with valid
	modport snk (
		input valid, sign, exp_a, exp_b, frac_a, frac_b,
		input special, special_word
	);

endinterface

// ==== fdiv_unpack.sv ====
/*
 * operand capture, field split and classification
 * selects the fixed result for nan, infinity and zero operands
 */

`timescale 1ns/100ps
`include "fdiv_macros.svh"

module fdiv_unpack (
	input  logic            rclk,        // divide pipe clock
	input  logic            i_rst_n,     // sync reset, active low
	input  logic            i_start,     // operation strobe
	input  logic            i_busy,      // divider occupied
	input  fdiv_pkg::word_t i_op_a,      // dividend
	input  fdiv_pkg::word_t i_op_b,      // divisor
	fdiv_stage_if.src       o_stage      // to normalization
);

	localparam int MAN_W = `FDIV_FRAC_W - 1;              // stored fraction bits
	localparam fdiv_pkg::word_t QNAN = 32'h7fc0_0000;     // default quiet nan

	fdiv_pkg::word_t op_q [2];           // 0 dividend, 1 divisor
	logic            valid_q;
	logic            sign;
	logic            exp_zero [2];       // zero or denormal
	logic            exp_max  [2];       // inf or nan
	logic            man_zero [2];
	logic            is_zero  [2];
	logic            is_inf   [2];
	logic            is_nan   [2];

	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_start & ~i_busy;              // strobes while busy dropped
		end
	end

	always_ff @(posedge rclk) begin
		if (i_start && !i_busy) begin
			op_q[0] <= i_op_a;
			op_q[1] <= i_op_b;
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			exp_zero[i] = (op_q[i][30:MAN_W] == 8'h00);
			exp_max[i]  = (op_q[i][30:MAN_W] == 8'hff);
			man_zero[i] = (op_q[i][MAN_W-1:0] == '0);
			is_zero[i]  = exp_zero[i] & man_zero[i];
			is_inf[i]   = exp_max[i] & man_zero[i];
			is_nan[i]   = exp_max[i] & ~man_zero[i];
		end
	end

	assign sign = op_q[0][31] ^ op_q[1][31];

	always_comb begin
		o_stage.valid  = valid_q;
		o_stage.sign   = sign;
		// denormals run with exponent 1 and no hidden bit
		o_stage.exp_a  = exp_zero[0] ? 10'd1 : {2'b00, op_q[0][30:MAN_W]};
		o_stage.exp_b  = exp_zero[1] ? 10'd1 : {2'b00, op_q[1][30:MAN_W]};
		o_stage.frac_a = {~exp_zero[0], op_q[0][MAN_W-1:0]};
		o_stage.frac_b = {~exp_zero[1], op_q[1][MAN_W-1:0]};

		o_stage.special      = 1'b1;
		o_stage.special_word = {sign, 31'd0};
		if (is_nan[0] || is_nan[1] || (is_inf[0] && is_inf[1]) ||
				(is_zero[0] && is_zero[1])) begin
			o_stage.special_word = QNAN;                   // invalid operation
		end else if (is_inf[0] || is_zero[1]) begin
			o_stage.special_word = {sign, 8'hff, {MAN_W{1'b0}}};   // inf or x/0
		end else if (is_zero[0] || is_inf[1]) begin
			o_stage.special_word = {sign, 31'd0};          // signed zero
		end else begin
			o_stage.special = 1'b0;                        // normal or denormal pair
		end
	end

	// the divider holds a single operation, upstream must wait for busy low
	a_start_busy: assert property (@(posedge rclk) disable iff (!i_rst_n)
		i_start |-> !i_busy)
		else $warning("input rule, i_start while busy is ignored");

endmodule

// ==== fdiv_norm.sv ====
/*
 * lead zero count and left shift of both significands
 * quotient exponent from the corrected operand exponents
 */

`timescale 1ns/100ps
`include "fdiv_macros.svh"

module fdiv_norm (
	input  logic      rclk,              // divide pipe clock
	input  logic      i_rst_n,           // sync reset, active low
	fdiv_stage_if.snk i_stage,           // unpacked operands
	fdiv_stage_if.src o_stage            // normalized operands
);

	localparam int FW = `FDIV_FRAC_W;

	fdiv_pkg::shl_cnt_t lz_a;            // dividend shift
	fdiv_pkg::shl_cnt_t lz_b;            // divisor shift
	fdiv_pkg::exp_t     exp_a_n;
	fdiv_pkg::exp_t     exp_b_n;
	fdiv_pkg::exp_t     exp_q;           // biased quotient exponent

	////////////////////////////////////////////////////////////////////////////
	// lead zero count
	////////////////////////////////////////////////////////////////////////////

	function automatic fdiv_pkg::shl_cnt_t lead0(input fdiv_pkg::frac_t f);
		fdiv_pkg::shl_cnt_t cnt;
		logic               found;
		cnt   = '0;
		found = 1'b0;
		for (int i = FW - 1; i >= 0; i--) begin
			if (!found && !f[i]) begin
				cnt = cnt + 1'b1;            // still in the zero run
			end else begin
				found = 1'b1;
			end
		end
		return cnt;
	endfunction

	assign lz_a = lead0(i_stage.frac_a);
	assign lz_b = lead0(i_stage.frac_b);

	////////////////////////////////////////////////////////////////////////////
	// exponent difference with shift correction
	////////////////////////////////////////////////////////////////////////////

	assign exp_a_n = i_stage.exp_a - fdiv_pkg::exp_t'(lz_a);
	assign exp_b_n = i_stage.exp_b - fdiv_pkg::exp_t'(lz_b);
	assign exp_q   = exp_a_n - exp_b_n + fdiv_pkg::exp_t'(`FDIV_EXP_BIAS);

	////////////////////////////////////////////////////////////////////////////
	// stage register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			o_stage.valid <= 1'b0;
		end else begin
			o_stage.valid <= i_stage.valid;
		end
	end

	always_ff @(posedge rclk) begin
		if (i_stage.valid) begin
			o_stage.sign         <= i_stage.sign;
			o_stage.exp_a        <= exp_q;                 // quotient exp from here on
			o_stage.exp_b        <= '0;
			o_stage.frac_a       <= i_stage.frac_a << lz_a;   // msb set
			o_stage.frac_b       <= i_stage.frac_b << lz_b;
			o_stage.special      <= i_stage.special;
			o_stage.special_word <= i_stage.special_word;
		end
	end

	// the fraction loop relies on both operands in [1,2)
	a_norm_msb: assert property (@(posedge rclk) disable iff (!i_rst_n)
		(o_stage.valid && !o_stage.special) |->
			(o_stage.frac_a[FW-1] && o_stage.frac_b[FW-1]))
		else $error("normalized significand without top bit");

endmodule

// ==== fdiv_frac_iter.sv ====
/*
 * restoring fraction divider, one quotient bit per cycle
 * iteration fsm, quotient shift register, busy flag
 */

`timescale 1ns/100ps
`include "fdiv_macros.svh"

module fdiv_frac_iter (
	input  logic      rclk,              // divide pipe clock
	input  logic      i_rst_n,           // sync reset, active low
	fdiv_stage_if.snk i_stage,           // normalized operands
	fdiv_stage_if.src o_stage,           // raw quotient
	output logic      o_busy             // divider occupied
);

	localparam int QBITS = `FDIV_QBITS;
	localparam int FW    = `FDIV_FRAC_W;

	fdiv_pkg::iter_state_t    state;
	logic [$clog2(QBITS)-1:0] iter_cnt;        // bits done, also done hold
	logic [FW:0]              rem;             // partial remainder, below 2x divisor
	fdiv_pkg::frac_t          divisor;
	fdiv_pkg::quot_t          quot;            // quotient shift register
	logic [FW+1:0]            trial;           // remainder minus divisor
	logic                     q_bit;
	logic                     load;
	logic                     valid_q;
	logic                     sign_q;
	fdiv_pkg::exp_t           exp_q;
	logic                     special_q;
	fdiv_pkg::word_t          special_word_q;

	assign load  = (state == fdiv_pkg::IDLE) && i_stage.valid;
	assign trial = {1'b0, rem} - {2'b00, divisor};
	assign q_bit = ~trial[FW+1];                       // no borrow

	////////////////////////////////////////////////////////////////////////////
	// iteration fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			state    <= fdiv_pkg::IDLE;
			iter_cnt <= '0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				fdiv_pkg::IDLE: begin
					iter_cnt <= '0;
					if (i_stage.valid) begin
						state <= fdiv_pkg::ITER;
					end
				end
				fdiv_pkg::ITER: begin
					if (iter_cnt == QBITS - 1) begin
						state    <= fdiv_pkg::DONE;
						iter_cnt <= '0;
						valid_q  <= 1'b1;        // last bit lands with this edge
					end else begin
						iter_cnt <= iter_cnt + 1'b1;
					end
				end
				fdiv_pkg::DONE: begin
					// second cycle covers the pack result register
					if (iter_cnt == 1'b1) begin
						state <= fdiv_pkg::IDLE;
					end
					iter_cnt <= iter_cnt + 1'b1;
				end
				default: begin
					state <= fdiv_pkg::IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// remainder and quotient
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge rclk) begin
		if (load) begin
			rem            <= {1'b0, i_stage.frac_a};   // dividend
			divisor        <= i_stage.frac_b;
			quot           <= '0;
			sign_q         <= i_stage.sign;
			exp_q          <= i_stage.exp_a;
			special_q      <= i_stage.special;
			special_word_q <= i_stage.special_word;
		end else if (state == fdiv_pkg::ITER) begin
			quot <= {quot[QBITS-2:0], q_bit};
			if (q_bit) begin
				rem <= {trial[FW-1:0], 1'b0};     // keep difference, double
			end else begin
				rem <= {rem[FW-1:0], 1'b0};       // restore, double
			end
		end
	end

	assign o_stage.valid        = valid_q;
	assign o_stage.sign         = sign_q;
	assign o_stage.exp_a        = exp_q;
	assign o_stage.exp_b        = '0;
	// 26 bit quotient split over both fraction fields, lsbs top aligned
	assign o_stage.frac_a       = quot[QBITS-1 -: FW];
	assign o_stage.frac_b       = {quot[QBITS-FW-1:0], {(2*FW-QBITS){1'b0}}};
	assign o_stage.special      = special_q;
	assign o_stage.special_word = special_word_q;

	assign o_busy = (state != fdiv_pkg::IDLE) || i_stage.valid;

	// exactly QBITS iteration cycles per accepted operation
	a_iter_len: assert property (@(posedge rclk) disable iff (!i_rst_n)
		load |=> (state == fdiv_pkg::ITER)[*QBITS] ##1 (state == fdiv_pkg::DONE))
		else $error("iteration count exceeds %0d", QBITS);

endmodule

// ==== fdiv_pack.sv ====
/*
 * quotient normalization, exponent range check
 * special override and result register
 */

`timescale 1ns/100ps
`include "fdiv_macros.svh"

module fdiv_pack (
	input  logic            rclk,        // divide pipe clock
	input  logic            i_rst_n,     // sync reset, active low
	fdiv_stage_if.snk       i_stage,     // raw quotient
	output logic            o_done,      // one cycle result strobe
	output fdiv_pkg::word_t o_result     // held until next done
);

	localparam int QBITS = `FDIV_QBITS;
	localparam int FW    = `FDIV_FRAC_W;

	fdiv_pkg::quot_t quot;               // rebuilt from both fraction fields
	fdiv_pkg::quot_t quot_n;             // integer bit set
	fdiv_pkg::exp_t  exp_n;
	fdiv_pkg::word_t result;

	assign quot = {i_stage.frac_a, i_stage.frac_b[FW-1 -: QBITS-FW]};

	// quotient of two [1,2) values is above 1/2, one shift at most
	assign quot_n = quot[QBITS-1] ? quot : {quot[QBITS-2:0], 1'b0};
	assign exp_n  = quot[QBITS-1] ? i_stage.exp_a : i_stage.exp_a - 10'sd1;

	always_comb begin
		if (i_stage.special) begin
			result = i_stage.special_word;
		end else if (exp_n >= 255) begin
			result = {i_stage.sign, 8'hff, {(FW-1){1'b0}}};     // overflow to inf
		end else if (exp_n <= 0) begin
			result = {i_stage.sign, 31'd0};                    // flush to zero
		end else begin
			// bits below the hidden bit, rest truncated
			result = {i_stage.sign, exp_n[7:0], quot_n[QBITS-2 -: FW-1]};
		end
	end

	always_ff @(posedge rclk) begin
		if (!i_rst_n) begin
			o_done   <= 1'b0;
			o_result <= '0;
		end else begin
			o_done <= i_stage.valid;
			if (i_stage.valid) begin
				o_result <= result;
			end
		end
	end

endmodule

// ==== fdiv_top.sv ====
/*
 * single precision divide pipe top level
 */

`timescale 1ns/100ps

module fdiv_top (
	input  logic            rclk,        // divide pipe clock
	input  logic            i_rst_n,     // sync reset, active low
	input  logic            i_start,     // operation strobe
	input  fdiv_pkg::word_t i_op_a,      // dividend
	input  fdiv_pkg::word_t i_op_b,      // divisor
	output logic            o_done,      // result strobe
	output logic            o_busy,      // strobe ignored while high
	output fdiv_pkg::word_t o_result     // truncated quotient
);

	fdiv_stage_if u2n ();                // unpack to norm
	fdiv_stage_if n2d ();                // norm to fraction loop
	fdiv_stage_if d2p ();                // fraction loop to pack

	logic iter_busy;

	// first cycle is still in the unpack register
	assign o_busy = iter_busy | u2n.valid;

	fdiv_unpack fdiv_unpack_i (
		.rclk    (rclk),
		.i_rst_n (i_rst_n),
		.i_start (i_start),
		.i_busy  (o_busy),
		.i_op_a  (i_op_a),
		.i_op_b  (i_op_b),
		.o_stage (u2n.src)
	);

	fdiv_norm fdiv_norm_i (
		.rclk    (rclk),
		.i_rst_n (i_rst_n),
		.i_stage (u2n.snk),
		.o_stage (n2d.src)
	);

	fdiv_frac_iter fdiv_frac_iter_i (
		.rclk    (rclk),
		.i_rst_n (i_rst_n),
		.i_stage (n2d.snk),
		.o_stage (d2p.src),
		.o_busy  (iter_busy)
	);

	fdiv_pack fdiv_pack_i (
		.rclk     (rclk),
		.i_rst_n  (i_rst_n),
		.i_stage  (d2p.snk),
		.o_done   (o_done),
		.o_result (o_result)
	);

endmodule

// ==== tb_fdiv.sv ====
/*
 * testbench for the divide pipe, vectors from fdiv_testdata.txt
 * checks reset values, results, done latency, busy and ignored strobes
 */

`timescale 1ns/100ps
`include "fdiv_macros.svh"

module tb_fdiv;

	localparam time CLK_PERIOD = 100;
	localparam int  RST_CYCLES = 5;
	localparam int  LAT        = `FDIV_LATENCY;

	logic            rclk;
	logic            i_rst_n;
	logic            i_start;
	fdiv_pkg::word_t i_op_a;
	fdiv_pkg::word_t i_op_b;
	logic            o_done;
	logic            o_busy;
	fdiv_pkg::word_t o_result;

	fdiv_pkg::word_t vec_a [$];          // dividends
	fdiv_pkg::word_t vec_b [$];          // divisors
	fdiv_pkg::word_t vec_q [$];          // expected quotients
	int              vec_cnt    = 0;
	bit              vec_loaded = 1'b0;
	int              mism_cnt   = 0;     // wrong values
	int              fail_cnt   = 0;     // protocol and file failures
	int              done_cnt   = 0;     // every done pulse seen
	int              seed       = 70;

	fdiv_top fdiv_top_i (
		.rclk     (rclk),
		.i_rst_n  (i_rst_n),
		.i_start  (i_start),
		.i_op_a   (i_op_a),
		.i_op_b   (i_op_b),
		.o_done   (o_done),
		.o_busy   (o_busy),
		.o_result (o_result)
	);

	initial begin : clock_gen
		rclk = 1'b0;
		forever #(CLK_PERIOD / 2) rclk = ~rclk;
	end

	always @(negedge rclk) begin
		if (i_rst_n === 1'b1 && o_done === 1'b1) begin
			done_cnt = done_cnt + 1;     // one negedge per pulse
		end
	end

	// budget of 40 cycles per vector plus reset and slack
	initial begin : watchdog
		wait (vec_loaded);
		repeat (vec_cnt * 40 + 100) @(posedge rclk);
		$display("%0t: timeout, the vectors did not complete in time", $time);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// vector file and one operation
	////////////////////////////////////////////////////////////////////////////

	task automatic load_vectors();
		int              fd;
		int              n;
		string           line;
		fdiv_pkg::word_t a;
		fdiv_pkg::word_t b;
		fdiv_pkg::word_t q;
		fd = $fopen("fdiv_testdata.txt", "r");
		if (fd == 0) begin
			fail_cnt++;
			$display("%0t: cannot open fdiv_testdata.txt", $time);
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && $sscanf(line, "%h %h %h", a, b, q) == 3) begin   // skips comments
				vec_a.push_back(a);
				vec_b.push_back(b);
				vec_q.push_back(q);
			end
		end
		$fclose(fd);
		vec_cnt = vec_a.size();
	endtask

	task automatic run_vector(input int idx);
		int              lat;
		int              strike_at;        // when the ignored strobe goes out
		bit              strike;
		fdiv_pkg::word_t hold;
		strike    = (idx % 8 == 3);
		strike_at = 2 + ($random(seed) & 15);
		lat       = 0;
		if (o_busy !== 1'b0) begin
			mism_cnt++;
			$display("Mismatch at %0t: o_busy = %b, expected 0 before vector %0d",
				$time, o_busy, idx);
		end
		i_start = 1'b1;
		i_op_a  = vec_a[idx];
		i_op_b  = vec_b[idx];
		do begin
			@(negedge rclk);
			lat++;
			i_start = 1'b0;
			if (o_busy !== 1'b1) begin
				mism_cnt++;
				$display("Mismatch at %0t: o_busy = %b, expected 1", $time, o_busy);
			end
			if (o_done !== 1'b1 && strike && lat == strike_at) begin
				i_start = 1'b1;              // must be dropped
				i_op_a  = $random(seed);
				i_op_b  = $random(seed);
			end
		end while (o_done !== 1'b1 && lat < LAT + 10);
		if (o_done !== 1'b1) begin
			fail_cnt++;
			$display("%0t: no done within %0d cycles of vector %0d", $time, lat, idx);
		end else begin
			if (lat != LAT) begin
				mism_cnt++;
				$display("Mismatch at %0t: o_done latency = %0d, expected %0d", $time, lat, LAT);
			end
			if (o_result !== vec_q[idx]) begin
				mism_cnt++;
				$display("Mismatch at %0t: o_result = %h, expected %h (%h / %h)",
					$time, o_result, vec_q[idx], vec_a[idx], vec_b[idx]);
			end
		end
		if (strike) begin
			hold = o_result;
			repeat (LAT + 4) begin           // long enough for a stray result
				@(negedge rclk);
				if (o_done !== 1'b0) begin
					mism_cnt++;
					$display("Mismatch at %0t: o_done = %b, expected 0",
						$time, o_done);
				end
				if (o_result !== hold) begin
					mism_cnt++;
					$display("Mismatch at %0t: o_result = %h, expected %h",
						$time, o_result, hold);
				end
			end
		end else begin
			@(negedge rclk);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		i_rst_n = 1'b0;
		i_start = 1'b0;
		i_op_a  = '0;
		i_op_b  = '0;
		load_vectors();
		if (vec_cnt == 0) begin
			fail_cnt++;
			$display("no vectors read from fdiv_testdata.txt");
		end
		vec_loaded = 1'b1;
		// one negedge after each reset edge and one after release
		for (int i = 0; i <= RST_CYCLES; i++) begin
			@(negedge rclk);
			if (i == RST_CYCLES - 1) begin
				i_rst_n = 1'b1;
			end
			if (o_done !== 1'b0 || o_busy !== 1'b0) begin
				mism_cnt++;
				$display("Mismatch at %0t: o_done/o_busy = %b/%b, expected 0/0",
					$time, o_done, o_busy);
			end
			if (o_result !== 32'h0) begin
				mism_cnt++;
				$display("Mismatch at %0t: o_result = %h, expected 0", $time, o_result);
			end
		end
		for (int i = 0; i < vec_cnt; i++) begin
			run_vector(i);
		end
		@(posedge rclk);
		if (done_cnt != vec_cnt) begin
			mism_cnt++;
			$display("Mismatch at %0t: done pulses = %0d, expected %0d", $time, done_cnt, vec_cnt);
		end
		$display("vectors %0d, mismatches %0d, other failures %0d", vec_cnt, mism_cnt, fail_cnt);
		if (mism_cnt == 0 && fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== fdiv_testdata.txt ====
// dividend divisor expected_quotient, hex single precision words
// quotient truncated toward zero, denormal results flushed to signed zero
3F800000 40400000 3EAAAAAA
40C00000 40000000 40400000
3F800000 3F800000 3F800000
C1200000 40A00000 C0000000
40000000 40400000 3F2AAAAA
3F800000 40E00000 3E124924
BF800000 40400000 BEAAAAAA
7F7FFFFF 3F800000 7F7FFFFF
00400000 3F000000 00800000
00000001 00000001 3F800000
0D000000 00400000 4C800000
3F800000 00600000 7EAAAAAA
00200000 00600000 3EAAAAAA
00000003 3F800000 00000000
7F000000 3E800000 7F800000
FF000000 3F000000 FF800000
00800000 40000000 00000000
80800000 4B000000 80000000
7F800001 3F800000 7FC00000
00000000 00000000 7FC00000
7F800000 FF800000 7FC00000
40000000 80000000 FF800000
00000000 C0000000 80000000
3F800000 7F800000 00000000

// ==== project.f ====
+incdir+.
fdiv_pkg.sv
fdiv_stage_if.sv
fdiv_unpack.sv
fdiv_norm.sv
fdiv_frac_iter.sv
fdiv_pack.sv
fdiv_top.sv
tb_fdiv.sv
